//--- rtl/isa_pkg.sv
// opcode and indexed postbyte encodings, 6809 style
// only the subset that the microcode knows is listed here
// any opcode not named below is treated as undefined by the decoder
package isa_pkg;

    typedef logic [7:0] op_t;   // opcode or postbyte
    typedef logic [3:0] idxm_t; // postbyte mode field, bits 3..0

    // immediate forms
    localparam op_t LDA_IMM  = 8'h86;
    localparam op_t ADDA_IMM = 8'h8b;
    localparam op_t CMPX_IMM = 8'h8c; // 16-bit immediate
    localparam op_t LDD_IMM  = 8'hcc; // 16-bit immediate

    // inherent
    localparam op_t NOP  = 8'h12;
    localparam op_t INCA = 8'h4c;
    localparam op_t CLRA = 8'h4f;

    // indexed
    localparam op_t LDA_IDX  = 8'ha6;
    localparam op_t STA_IDX  = 8'ha7;
    localparam op_t ADDA_IDX = 8'hab;
    localparam op_t LDD_IDX  = 8'hec;

    // flow control
    localparam op_t LBRA = 8'h16;
    localparam op_t BRA  = 8'h20;
    localparam op_t BNE  = 8'h26;
    localparam op_t RTI  = 8'h3b;

    // postbyte layout
    localparam int unsigned IDX_MODE_BIT = 7; // clear means 5-bit offset form
    localparam int unsigned IDX_IND_BIT  = 4; // set means indirect

    // postbyte modes when bit 7 is set
    localparam idxm_t IDXM_RINC   = 4'd0;  // ,R+
    localparam idxm_t IDXM_RINC2  = 4'd1;  // ,R++
    localparam idxm_t IDXM_RDEC   = 4'd2;  // ,-R
    localparam idxm_t IDXM_RDEC2  = 4'd3;  // ,--R
    localparam idxm_t IDXM_ZERO   = 4'd4;  // ,R
    localparam idxm_t IDXM_ACC_B  = 4'd5;  // B,R
    localparam idxm_t IDXM_ACC_A  = 4'd6;  // A,R
    localparam idxm_t IDXM_OFF8   = 4'd8;
    localparam idxm_t IDXM_OFF16  = 4'd9;
    localparam idxm_t IDXM_ACC_D  = 4'd11; // D,R
    localparam idxm_t IDXM_PCR8   = 4'd12; // 8-bit offset from pc
    localparam idxm_t IDXM_PCR16  = 4'd13; // 16-bit offset from pc
    localparam idxm_t IDXM_EXTIND = 4'd15; // [n16]
    // 7, 10 and 14 have no microcode and end in the bus error routine

endpackage

//--- rtl/ucode_pkg.sv
// microcode address map and control word layout
// an address is a 4-bit category on top of a 4-bit row, 16 rows per routine
// the control word is fixed at 23 bits, one per strobe
package ucode_pkg;

    typedef logic [7:0] uaddr_t;
    typedef logic [3:0] urow_t;

    typedef enum logic [3:0] {
        RESET        = 4'd0,
        SINGLE_ALU   = 4'd1,
        SINGLE_ALU16 = 4'd2,
        ALU_INH      = 4'd3,
        PARSE_IDX    = 4'd4,
        ALU_IDX      = 4'd5,
        ALU_IDX16    = 4'd6,
        BRANCH8      = 4'd7,
        BRANCH16     = 4'd8,
        RTIT         = 4'd9,
        STORE        = 4'd10,
        IDX_MODES    = 4'd11,
        NMI_V        = 4'd12,
        FIRQ_V       = 4'd13,
        IRQ_V        = 4'd14,
        BUSERROR     = 4'd15
    } opcat_t;

    // entry rows of the postbyte handlers inside IDX_MODES
    localparam urow_t ROW_SUM      = 4'd0;
    localparam urow_t ROW_RINC     = 4'd2;
    localparam urow_t ROW_RINC2    = 4'd4;
    localparam urow_t ROW_RDEC     = 4'd6;
    localparam urow_t ROW_RDEC2    = 4'd8;
    localparam urow_t ROW_OFFSET8  = 4'd10;
    localparam urow_t ROW_OFFSET16 = 4'd12;
    localparam urow_t ROW_EXTIND   = 4'd14;

    localparam int unsigned UW_BITS = 23;
    typedef logic [UW_BITS-1:0] ucode_word_t;

    // bit positions, msb first in port order
    localparam int unsigned UB_NI              = 22;
    localparam int unsigned UB_JMP_IDX         = 21;
    localparam int unsigned UB_IDX_RET         = 20;
    localparam int unsigned UB_SKIP_NOIND      = 19;
    localparam int unsigned UB_HALT            = 18;
    localparam int unsigned UB_UPLD8           = 17;
    localparam int unsigned UB_UPLD16          = 16;
    localparam int unsigned UB_MEM16           = 15;
    localparam int unsigned UB_MEMHI           = 14;
    localparam int unsigned UB_OPD             = 13;
    localparam int unsigned UB_SET_OPN0_A      = 12;
    localparam int unsigned UB_SET_OPN0_MEM    = 11;
    localparam int unsigned UB_ADR_IDX         = 10;
    localparam int unsigned UB_INCX            = 9;
    localparam int unsigned UB_DECX            = 8;
    localparam int unsigned UB_WE              = 7;
    localparam int unsigned UB_SET_PC_BRANCH8  = 6;
    localparam int unsigned UB_SET_PC_BRANCH16 = 5;
    localparam int unsigned UB_SET_PC_INT      = 4;
    localparam int unsigned UB_PSHALL          = 3;
    localparam int unsigned UB_PSHCC           = 2;
    localparam int unsigned UB_PUL_PC          = 1;
    localparam int unsigned UB_RTI_CC          = 0;

    function automatic uaddr_t uaddr(input opcat_t cat, input urow_t row);
        return {cat, row};
    endfunction

endpackage

//--- rtl/op_decode.sv
// opcode to microcode routine category, purely combinational
// indexed opcodes enter PARSE_IDX first; after_cat names the routine
// to resume in once the postbyte is handled
// after_cat is only meaningful when opcat is PARSE_IDX
`timescale 1ns/10ps

module op_decode
    import isa_pkg::*;
    import ucode_pkg::*;
(
    input  op_t    op,
    output opcat_t opcat,
    output opcat_t after_cat
);

    always_comb begin
        opcat     = BUSERROR; // undefined opcodes stop the core
        after_cat = RESET;
        case (op)
            // 8-bit immediate operand
            LDA_IMM,
            ADDA_IMM: opcat = SINGLE_ALU;

            // 16-bit immediate operand
            LDD_IMM,
            CMPX_IMM: opcat = SINGLE_ALU16;

            // register only, nothing fetched
            CLRA,
            INCA,
            NOP: opcat = ALU_INH;

            BRA,
            BNE: opcat = BRANCH8;  // condition is evaluated outside

            LBRA: opcat = BRANCH16;

            RTI: opcat = RTIT;

            // indexed, 8-bit operand
            LDA_IDX,
            ADDA_IDX: begin
                opcat     = PARSE_IDX;
                after_cat = ALU_IDX;
            end

            // indexed, 16-bit operand
            LDD_IDX: begin
                opcat     = PARSE_IDX;
                after_cat = ALU_IDX16;
            end

            // indexed store
            STA_IDX: begin
                opcat     = PARSE_IDX;
                after_cat = STORE;
            end

            default: begin
                opcat     = BUSERROR;
                after_cat = RESET;
            end
        endcase
    end

endmodule

//--- rtl/ucode_rom.sv
// microcode store as a constant table, read combinationally
// unlisted rows read as all zeros, except in BUSERROR where every row halts
`timescale 1ns/10ps

module ucode_rom
    import ucode_pkg::*;
(
    input  uaddr_t      upc,
    output ucode_word_t ctrl
);

    opcat_t cat;
    urow_t  row;

    assign cat = opcat_t'(upc[7:4]);
    assign row = upc[3:0];

    always_comb begin
        ctrl = '0;
        case (cat)
            RESET: begin
                if (row == 4'd0) ctrl[UB_SET_PC_INT] = 1'b1; // load reset vector
                if (row == 4'd1) ctrl[UB_NI] = 1'b1;
            end
            SINGLE_ALU: begin
                if (row == 4'd0) begin
                    ctrl[UB_UPLD8] = 1'b1;
                    ctrl[UB_OPD]   = 1'b1;
                end
                if (row == 4'd1) ctrl[UB_NI] = 1'b1;
            end
            SINGLE_ALU16: begin
                if (row == 4'd0) ctrl[UB_MEM16] = 1'b1;
                if (row == 4'd1) ctrl[UB_UPLD16] = 1'b1;
                if (row == 4'd2) ctrl[UB_NI] = 1'b1;
            end
            ALU_INH: begin
                if (row == 4'd0) begin
                    ctrl[UB_SET_OPN0_A] = 1'b1;
                    ctrl[UB_NI]         = 1'b1;
                end
            end
            PARSE_IDX: begin
                if (row == 4'd0) ctrl[UB_JMP_IDX] = 1'b1; // dispatch on postbyte
            end
            IDX_MODES: begin
                // each handler is one address step and a return
                case (row)
                    ROW_SUM:      ctrl[UB_ADR_IDX] = 1'b1;
                    ROW_RINC:     ctrl[UB_INCX]    = 1'b1;
                    ROW_RINC2:    ctrl[UB_INCX]    = 1'b1;
                    ROW_RDEC:     ctrl[UB_DECX]    = 1'b1;
                    ROW_RDEC2:    ctrl[UB_DECX]    = 1'b1;
                    ROW_OFFSET8:  ctrl[UB_UPLD8]   = 1'b1;
                    ROW_OFFSET16: begin
                        ctrl[UB_UPLD16] = 1'b1;
                        ctrl[UB_MEM16]  = 1'b1;
                    end
                    ROW_EXTIND:   ctrl[UB_MEMHI]   = 1'b1;
                    default:      ctrl[UB_IDX_RET] = 1'b1; // odd rows
                endcase
            end
            ALU_IDX: begin
                if (row == 4'd0) ctrl[UB_SKIP_NOIND] = 1'b1; // jumps over the indirect read
                if (row == 4'd1) ctrl[UB_MEMHI] = 1'b1;
                if (row == 4'd2) begin
                    ctrl[UB_SET_OPN0_MEM] = 1'b1;
                    ctrl[UB_NI]           = 1'b1;
                end
            end
            ALU_IDX16: begin
                if (row == 4'd0) ctrl[UB_MEM16] = 1'b1;
                if (row == 4'd1) begin
                    ctrl[UB_SET_OPN0_MEM] = 1'b1;
                    ctrl[UB_NI]           = 1'b1;
                end
            end
            BRANCH8: begin
                if (row == 4'd0) begin
                    ctrl[UB_SET_PC_BRANCH8] = 1'b1;
                    ctrl[UB_NI]             = 1'b1;
                end
            end
            BRANCH16: begin
                if (row == 4'd0) ctrl[UB_MEM16] = 1'b1;
                if (row == 4'd1) begin
                    ctrl[UB_SET_PC_BRANCH16] = 1'b1;
                    ctrl[UB_NI]              = 1'b1;
                end
            end
            RTIT: begin
                if (row == 4'd0) ctrl[UB_RTI_CC] = 1'b1;
                if (row == 4'd1) ctrl[UB_PUL_PC] = 1'b1;
                if (row == 4'd2) ctrl[UB_NI] = 1'b1;
            end
            STORE: begin
                if (row == 4'd0) ctrl[UB_WE] = 1'b1;
                if (row == 4'd1) ctrl[UB_NI] = 1'b1;
            end
            NMI_V,
            IRQ_V,
            FIRQ_V: begin
                // firq only stacks cc, the others stack everything
                if (row == 4'd0 && cat == FIRQ_V) ctrl[UB_PSHCC] = 1'b1;
                if (row == 4'd0 && cat != FIRQ_V) ctrl[UB_PSHALL] = 1'b1;
                if (row == 4'd1) ctrl[UB_SET_PC_INT] = 1'b1;
                if (row == 4'd2) ctrl[UB_NI] = 1'b1;
            end
            BUSERROR: ctrl[UB_HALT] = 1'b1; // every row, so a stray jump still stops
            default: ctrl = '0;
        endcase
    end

endmodule

//--- rtl/ucode_seq.sv
// microcode sequencer: upc register and next address selection
// steps only when cen is high; halt, mem_busy and alu_busy freeze it
// interrupts are levels sampled on ni rows only, nmi > firq > irq
// int_en is set on firq or irq entry and cleared by the rti_cc row
`timescale 1ns/10ps

module ucode_seq
    import isa_pkg::*;
    import ucode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  op_t         op,
    input  opcat_t      opcat,
    input  opcat_t      after_cat,
    input  ucode_word_t ctrl,
    input  logic        mem_busy,
    input  logic        alu_busy,
    input  logic        irq,
    input  logic        firq,
    input  logic        nmi,
    output uaddr_t      upc,
    output logic        int_en
);

    opcat_t after_idx;  // routine to resume after the postbyte handler
    uaddr_t idx_dst;    // handler selected by the postbyte
    logic   step;

    assign step = cen && !ctrl[UB_HALT] && !mem_busy && !alu_busy;

    // postbyte mode to handler row
    always_comb begin
        if (!op[IDX_MODE_BIT]) begin
            idx_dst = uaddr(IDX_MODES, ROW_SUM); // 5-bit offset form
        end else begin
            case (idxm_t'(op[3:0]))
                IDXM_RINC:   idx_dst = uaddr(IDX_MODES, ROW_RINC);
                IDXM_RINC2:  idx_dst = uaddr(IDX_MODES, ROW_RINC2);
                IDXM_RDEC:   idx_dst = uaddr(IDX_MODES, ROW_RDEC);
                IDXM_RDEC2:  idx_dst = uaddr(IDX_MODES, ROW_RDEC2);
                IDXM_ZERO,
                IDXM_ACC_B,
                IDXM_ACC_A,
                IDXM_ACC_D:  idx_dst = uaddr(IDX_MODES, ROW_SUM);
                IDXM_OFF8,
                IDXM_PCR8:   idx_dst = uaddr(IDX_MODES, ROW_OFFSET8);
                IDXM_OFF16,
                IDXM_PCR16:  idx_dst = uaddr(IDX_MODES, ROW_OFFSET16);
                IDXM_EXTIND: idx_dst = uaddr(IDX_MODES, ROW_EXTIND);
                default:     idx_dst = uaddr(BUSERROR, 4'd0); // modes 7, 10, 14
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            upc       <= uaddr(RESET, 4'd0);
            int_en    <= 1'b0;
            after_idx <= RESET;
        end else if (step) begin
            if (ctrl[UB_RTI_CC]) int_en <= 1'b0;

            if (ctrl[UB_NI]) begin
                if (nmi) begin
                    upc <= uaddr(NMI_V, 4'd0); // int_en left alone
                end else if (firq) begin
                    upc    <= uaddr(FIRQ_V, 4'd0);
                    int_en <= 1'b1;
                end else if (irq) begin
                    upc    <= uaddr(IRQ_V, 4'd0);
                    int_en <= 1'b1;
                end else begin
                    upc       <= uaddr(opcat, 4'd0);
                    after_idx <= after_cat;
                end
            end else if (ctrl[UB_JMP_IDX]) begin
                upc <= idx_dst;
            end else if (ctrl[UB_IDX_RET]) begin
                upc <= uaddr(after_idx, 4'd0);
            end else if (ctrl[UB_SKIP_NOIND] && !op[IDX_IND_BIT]) begin
                upc <= upc + 8'd2; // direct operand, no pointer fetch
            end else begin
                upc <= upc + 8'd1;
            end
        end
    end

endmodule

//--- rtl/ucode_ctrl.sv
// microcode control unit top: decoder, sequencer and store
// control outputs are combinational from upc, no handshake
// upc is brought out as a trace port for debug
`timescale 1ns/10ps

module ucode_ctrl
    import isa_pkg::*;
    import ucode_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   cen,
    input  op_t    op,        // opcode or postbyte from the fetch path
    input  logic   mem_busy,
    input  logic   alu_busy,
    input  logic   irq,
    input  logic   firq,
    input  logic   nmi,
    output uaddr_t upc,
    output logic   int_en,
    output logic   ni,
    output logic   jmp_idx,
    output logic   idx_ret,
    output logic   skip_noind,
    output logic   halt,
    output logic   upld8,
    output logic   upld16,
    output logic   mem16,
    output logic   memhi,
    output logic   opd,
    output logic   set_opn0_a,
    output logic   set_opn0_mem,
    output logic   adr_idx,
    output logic   incx,
    output logic   decx,
    output logic   we,
    output logic   set_pc_branch8,
    output logic   set_pc_branch16,
    output logic   set_pc_int,
    output logic   pshall,
    output logic   pshcc,
    output logic   pul_pc,
    output logic   rti_cc
);

    opcat_t      opcat;
    opcat_t      after_cat;
    ucode_word_t ctrl;

    op_decode u_decode (
        .op        (op),
        .opcat     (opcat),
        .after_cat (after_cat)
    );

    ucode_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op        (op),
        .opcat     (opcat),
        .after_cat (after_cat),
        .ctrl      (ctrl),
        .mem_busy  (mem_busy),
        .alu_busy  (alu_busy),
        .irq       (irq),
        .firq      (firq),
        .nmi       (nmi),
        .upc       (upc),
        .int_en    (int_en)
    );

    ucode_rom u_rom (
        .upc  (upc),
        .ctrl (ctrl)
    );

    // control word fan out
    assign ni              = ctrl[UB_NI];
    assign jmp_idx         = ctrl[UB_JMP_IDX];
    assign idx_ret         = ctrl[UB_IDX_RET];
    assign skip_noind      = ctrl[UB_SKIP_NOIND];
    assign halt            = ctrl[UB_HALT];
    assign upld8           = ctrl[UB_UPLD8];
    assign upld16          = ctrl[UB_UPLD16];
    assign mem16           = ctrl[UB_MEM16];
    assign memhi           = ctrl[UB_MEMHI];
    assign opd             = ctrl[UB_OPD];
    assign set_opn0_a      = ctrl[UB_SET_OPN0_A];
    assign set_opn0_mem    = ctrl[UB_SET_OPN0_MEM];
    assign adr_idx         = ctrl[UB_ADR_IDX];
    assign incx            = ctrl[UB_INCX];
    assign decx            = ctrl[UB_DECX];
    assign we              = ctrl[UB_WE];
    assign set_pc_branch8  = ctrl[UB_SET_PC_BRANCH8];
    assign set_pc_branch16 = ctrl[UB_SET_PC_BRANCH16];
    assign set_pc_int      = ctrl[UB_SET_PC_INT];
    assign pshall          = ctrl[UB_PSHALL];
    assign pshcc           = ctrl[UB_PSHCC];
    assign pul_pc          = ctrl[UB_PUL_PC];
    assign rti_cc          = ctrl[UB_RTI_CC];

endmodule

//--- verification/ucode_ctrl_asserts.sv
// concurrent checks on the microcode sequencer, bound into ucode_seq
// hold and halt checks are off while rst is high
`timescale 1ns/10ps

module ucode_ctrl_asserts
    import ucode_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        cen,
    input logic        mem_busy,
    input logic        alu_busy,
    input ucode_word_t ctrl,
    input uaddr_t      upc
);

    upc_zero_after_reset: assert property (@(posedge clk) rst |=> upc == 8'h00)
        else $error("upc is not zero after reset");

    halt_freezes_upc: assert property (
        @(posedge clk) disable iff (rst) ctrl[UB_HALT] |=> $stable(upc))
        else $error("upc moved on a halt row");

    // cen low or either busy holds the sequencer
    hold_freezes_upc: assert property (
        @(posedge clk) disable iff (rst) (!cen || mem_busy || alu_busy) |=> $stable(upc))
        else $error("upc moved while held");

    one_sequencing_bit: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({ctrl[UB_NI], ctrl[UB_JMP_IDX], ctrl[UB_IDX_RET]}))
        else $error("more than one of ni, jmp_idx, idx_ret in a word");

endmodule

bind ucode_seq ucode_ctrl_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .mem_busy (mem_busy),
    .alu_busy (alu_busy),
    .ctrl     (ctrl),
    .upc      (upc)
);

//--- verification/ucode_ctrl_tb.sv
// testbench for the microcode control unit
// one table entry per instruction; a reference model predicts upc on every edge
// random cen and busy gaps come from $urandom, seeded once
// inputs change 2 ns after the rising edge, outputs are checked there too
`timescale 1ns/10ps

module ucode_ctrl_tb
    import isa_pkg::*;
    import ucode_pkg::*;
();

    typedef struct packed {
        logic [7:0] opc;    // opcode presented at ni
        logic [7:0] pb;     // postbyte presented inside the routine
        logic [2:0] ints;   // nmi, firq, irq at the ni
        logic [3:0] busy;   // held cycles before dispatch
        logic [3:0] cat;    // category entered after ni
        logic [3:0] steps;  // steps to next ni, 0 means bus error
        logic       rnd;    // random gaps inside the routine
    } entry_t;

    localparam int N_ENT = 34;

    entry_t tbl [N_ENT] = '{
        '{LDA_IMM,  8'h00, 3'b000, 4'd0, SINGLE_ALU,   4'd2, 1'b0},
        '{ADDA_IMM, 8'h00, 3'b000, 4'd3, SINGLE_ALU,   4'd2, 1'b1},
        '{LDD_IMM,  8'h00, 3'b000, 4'd0, SINGLE_ALU16, 4'd3, 1'b1},
        '{CMPX_IMM, 8'h00, 3'b000, 4'd2, SINGLE_ALU16, 4'd3, 1'b0},
        '{CLRA,     8'h00, 3'b000, 4'd0, ALU_INH,      4'd1, 1'b0},
        '{INCA,     8'h00, 3'b000, 4'd4, ALU_INH,      4'd1, 1'b0},
        '{NOP,      8'h00, 3'b000, 4'd0, ALU_INH,      4'd1, 1'b1},
        '{BRA,      8'h00, 3'b000, 4'd0, BRANCH8,      4'd1, 1'b0},
        '{BNE,      8'h00, 3'b000, 4'd1, BRANCH8,      4'd1, 1'b0},
        '{LBRA,     8'h00, 3'b000, 4'd0, BRANCH16,     4'd2, 1'b1},
        '{LDA_IDX,  8'h05, 3'b000, 4'd0, PARSE_IDX,    4'd5, 1'b0}, // 5-bit offset
        '{LDA_IDX,  8'h80, 3'b000, 4'd0, PARSE_IDX,    4'd5, 1'b0},
        '{ADDA_IDX, 8'h91, 3'b000, 4'd0, PARSE_IDX,    4'd6, 1'b1}, // indirect
        '{ADDA_IDX, 8'h82, 3'b000, 4'd2, PARSE_IDX,    4'd5, 1'b1},
        '{LDD_IDX,  8'h83, 3'b000, 4'd0, PARSE_IDX,    4'd5, 1'b0},
        '{LDD_IDX,  8'h94, 3'b000, 4'd0, PARSE_IDX,    4'd5, 1'b0},
        '{STA_IDX,  8'h88, 3'b000, 4'd0, PARSE_IDX,    4'd5, 1'b0},
        '{STA_IDX,  8'h89, 3'b000, 4'd0, PARSE_IDX,    4'd5, 1'b1},
        '{LDA_IDX,  8'h9f, 3'b000, 4'd0, PARSE_IDX,    4'd6, 1'b0},
        '{LDA_IDX,  8'h8c, 3'b000, 4'd0, PARSE_IDX,    4'd5, 1'b0},
        '{ADDA_IDX, 8'h9d, 3'b000, 4'd0, PARSE_IDX,    4'd6, 1'b0},
        '{LDA_IDX,  8'h8b, 3'b000, 4'd1, PARSE_IDX,    4'd5, 1'b0},
        '{LDD_IDX,  8'h85, 3'b000, 4'd0, PARSE_IDX,    4'd5, 1'b0}, // B,R
        '{STA_IDX,  8'h96, 3'b000, 4'd0, PARSE_IDX,    4'd5, 1'b1}, // A,R
        '{NOP,      8'h00, 3'b001, 4'd2, IRQ_V,        4'd3, 1'b0},
        '{RTI,      8'h00, 3'b000, 4'd0, RTIT,         4'd3, 1'b0},
        '{NOP,      8'h00, 3'b011, 4'd0, FIRQ_V,       4'd3, 1'b1},
        '{RTI,      8'h00, 3'b000, 4'd0, RTIT,         4'd3, 1'b0},
        '{NOP,      8'h00, 3'b111, 4'd0, NMI_V,        4'd3, 1'b0},
        '{8'h01,    8'h00, 3'b000, 4'd0, BUSERROR,     4'd0, 1'b0}, // undefined
        '{LDA_IDX,  8'h87, 3'b000, 4'd0, PARSE_IDX,    4'd0, 1'b0},
        '{STA_IDX,  8'h8a, 3'b000, 4'd0, PARSE_IDX,    4'd0, 1'b0},
        '{LDD_IDX,  8'h9e, 3'b000, 4'd0, PARSE_IDX,    4'd0, 1'b0},
        '{LDA_IMM,  8'h00, 3'b000, 4'd0, SINGLE_ALU,   4'd2, 1'b0}
    };

    logic   clk = 1'b0;
    logic   rst, cen, mem_busy, alu_busy, irq, firq, nmi;
    op_t    op;
    uaddr_t upc;
    logic   int_en;
    logic   ni, jmp_idx, idx_ret, skip_noind, halt, upld8, upld16, mem16, memhi, opd;
    logic   set_opn0_a, set_opn0_mem, adr_idx, incx, decx, we;
    logic   set_pc_branch8, set_pc_branch16, set_pc_int, pshall, pshcc, pul_pc, rti_cc;
    logic [22:0] strobes;
    logic [31:0] outs;

    uaddr_t     exp_upc;
    logic       exp_int_en;
    logic [3:0] exp_after;  // category to resume after the postbyte
    int         val_errs;
    int         flow_errs;

    ucode_ctrl dut_i (.*);

    assign strobes = {ni, jmp_idx, idx_ret, skip_noind, halt, upld8, upld16, mem16,
                      memhi, opd, set_opn0_a, set_opn0_mem, adr_idx, incx, decx, we,
                      set_pc_branch8, set_pc_branch16, set_pc_int, pshall, pshcc,
                      pul_pc, rti_cc};
    assign outs = {upc, int_en, strobes};

    always #20 clk = ~clk;

    // {ni, jmp_idx, idx_ret, skip_noind, halt} per microcode address
    function automatic logic [4:0] seq_bits(input logic [7:0] a);
        logic [3:0] r;
        logic [4:0] s;
        r = a[3:0];
        s = '0;
        case (a[7:4])
            4'd3, 4'd7:                     s[4] = (r == 4'd0);
            4'd0, 4'd1, 4'd6, 4'd8, 4'd10:  s[4] = (r == 4'd1);
            4'd2, 4'd9, 4'd12, 4'd13, 4'd14: s[4] = (r == 4'd2);
            4'd4:  s[3] = (r == 4'd0);
            4'd11: s[2] = r[0];             // odd rows return
            4'd5: begin
                s[1] = (r == 4'd0);
                s[4] = (r == 4'd2);
            end
            default: s[0] = 1'b1;           // bus error, every row
        endcase
        return s;
    endfunction

    // {set_pc_int, we, rti_cc, pshcc, pshall}
    function automatic logic [4:0] strobe_ref(input logic [7:0] a);
        logic [4:0] s;
        s[4] = (a == 8'h00) || (a == 8'hc1) || (a == 8'hd1) || (a == 8'he1);
        s[3] = (a == 8'ha0);
        s[2] = (a == 8'h90);
        s[1] = (a == 8'hd0);
        s[0] = (a == 8'hc0) || (a == 8'he0);
        return s;
    endfunction

    // {after category, entry category}
    function automatic logic [7:0] decode_ref(input logic [7:0] opc);
        case (opc)
            LDA_IMM, ADDA_IMM:  return {RESET, SINGLE_ALU};
            LDD_IMM, CMPX_IMM:  return {RESET, SINGLE_ALU16};
            CLRA, INCA, NOP:    return {RESET, ALU_INH};
            BRA, BNE:           return {RESET, BRANCH8};
            LBRA:               return {RESET, BRANCH16};
            RTI:                return {RESET, RTIT};
            LDA_IDX, ADDA_IDX:  return {ALU_IDX, PARSE_IDX};
            LDD_IDX:            return {ALU_IDX16, PARSE_IDX};
            STA_IDX:            return {STORE, PARSE_IDX};
            default:            return {RESET, BUSERROR};
        endcase
    endfunction

    function automatic logic [7:0] mode_ref(input logic [7:0] pb);
        if (!pb[7]) return 8'hb0;
        case (pb[3:0])
            4'd0:                      return 8'hb2;
            4'd1:                      return 8'hb4;
            4'd2:                      return 8'hb6;
            4'd3:                      return 8'hb8;
            4'd4, 4'd5, 4'd6, 4'd11:   return 8'hb0;
            4'd8, 4'd12:               return 8'hba;
            4'd9, 4'd13:               return 8'hbc;
            4'd15:                     return 8'hbe;
            default:                   return 8'hf0;
        endcase
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        val_errs++;
    endtask

    // one clock edge with the inputs as driven now, then compare with the model
    task automatic advance();
        logic [4:0]  sb;
        logic [7:0]  dec;
        logic [31:0] snap;
        logic        held;
        uaddr_t      nxt;
        sb   = seq_bits(exp_upc);
        dec  = decode_ref(op);
        held = !cen || sb[0] || mem_busy || alu_busy;
        snap = outs;
        nxt  = exp_upc;
        if (!held) begin
            if (exp_upc == 8'h90) exp_int_en = 1'b0; // rti_cc row
            if (sb[4]) begin
                if (nmi) begin
                    nxt = 8'hc0;
                end else if (firq) begin
                    nxt = 8'hd0;
                    exp_int_en = 1'b1;
                end else if (irq) begin
                    nxt = 8'he0;
                    exp_int_en = 1'b1;
                end else begin
                    nxt = {dec[3:0], 4'h0};
                    exp_after = dec[7:4];
                end
            end else if (sb[3]) begin
                nxt = mode_ref(op);
            end else if (sb[2]) begin
                nxt = {exp_after, 4'h0};
            end else if (sb[1] && !op[4]) begin
                nxt = exp_upc + 8'd2;
            end else begin
                nxt = exp_upc + 8'd1;
            end
        end
        @(posedge clk);
        #2;
        exp_upc = nxt;
        sb = seq_bits(exp_upc);
        if (upc !== exp_upc) report_value("upc", 32'(upc), 32'(exp_upc));
        if (int_en !== exp_int_en) report_value("int_en", 32'(int_en), 32'(exp_int_en));
        if (ni !== sb[4]) report_value("ni", 32'(ni), 32'(sb[4]));
        if (halt !== sb[0]) report_value("halt", 32'(halt), 32'(sb[0]));
        if ({jmp_idx, idx_ret, skip_noind} !== sb[3:1])
            report_value("jmp_idx,idx_ret,skip_noind", 32'({jmp_idx, idx_ret, skip_noind}),
                         32'(sb[3:1]));
        if ({set_pc_int, we, rti_cc, pshcc, pshall} !== strobe_ref(exp_upc))
            report_value("set_pc_int,we,rti_cc,pshcc,pshall",
                         32'({set_pc_int, we, rti_cc, pshcc, pshall}),
                         32'(strobe_ref(exp_upc)));
        if (held && outs !== snap) report_value("outputs while held", outs, snap);
    endtask

    // kind 0 cen low, 1 mem_busy, 2 alu_busy
    task automatic hold_gap(input int n, input int kind);
        for (int i = 0; i < n; i++) begin
            cen      = (kind != 0);
            mem_busy = (kind == 1);
            alu_busy = (kind == 2);
            advance();
        end
        cen      = 1'b1;
        mem_busy = 1'b0;
        alu_busy = 1'b0;
    endtask

    task automatic apply_reset();
        rst      = 1'b1;
        cen      = 1'b1;
        mem_busy = 1'b0;
        alu_busy = 1'b0;
        {nmi, firq, irq} = 3'b000;
        op       = NOP;
        repeat (4) @(posedge clk);
        #2;
        rst        = 1'b0;
        exp_upc    = 8'h00;
        exp_int_en = 1'b0;
        exp_after  = 4'd0;
        if (upc !== 8'h00) report_value("upc", 32'(upc), 32'h0);
        if (int_en !== 1'b0) report_value("int_en", 32'(int_en), 32'h0);
        if (strobes !== 23'h000010) report_value("strobes", 32'(strobes), 32'h10);
        advance();  // reset routine ends on its ni row
        if (ni !== 1'b1) begin
            $display("reset routine did not reach its ni row at %0t", $time);
            flow_errs++;
        end
    endtask

    initial begin
        #(N_ENT * 40 * 40);
        $display("watchdog expired before the table was finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int     steps;
        int     gap;
        entry_t e;
        rst = 1'b1;
        cen = 1'b0;
        mem_busy = 1'b0;
        alu_busy = 1'b0;
        {nmi, firq, irq} = 3'b000;
        op = 8'h00;
        val_errs = 0;
        flow_errs = 0;
        exp_upc = 8'h00;
        exp_int_en = 1'b0;
        exp_after = 4'd0;
        void'($urandom(2746));
        @(posedge clk);
        #2;
        apply_reset();
        for (int k = 0; k < N_ENT; k++) begin
            e  = tbl[k];
            op = e.opc;
            {nmi, firq, irq} = e.ints;
            hold_gap(int'(e.busy), 1 + k % 2); // interrupts must wait for the step
            advance();
            {nmi, firq, irq} = 3'b000;
            op = e.pb;
            if (upc !== {e.cat, 4'h0}) report_value("entry upc", 32'(upc), 32'({e.cat, 4'h0}));
            steps = 1;
            while (!ni && !halt && steps < 16) begin
                if (e.rnd) begin
                    gap = $urandom_range(0, 2);
                    hold_gap(gap, $urandom_range(0, 2));
                end
                advance();
                steps++;
            end
            if (e.steps == 4'd0) begin
                if (halt !== 1'b1) begin
                    $display("entry %0d did not end in the bus error routine", k);
                    flow_errs++;
                end
                repeat (3) advance(); // frozen until reset
                apply_reset();
            end else if (!ni) begin
                $display("entry %0d reached no ni within 16 steps", k);
                flow_errs++;
            end else if (steps != int'(e.steps)) begin
                $display("entry %0d took %0d steps to ni, expected %0d", k, steps, e.steps);
                flow_errs++;
            end
        end
        $display("errors: %0d value mismatches, %0d sequence errors", val_errs, flow_errs);
        if (val_errs + flow_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- ucode_ctrl.f
rtl/isa_pkg.sv
rtl/ucode_pkg.sv
rtl/op_decode.sv
rtl/ucode_rom.sv
rtl/ucode_seq.sv
rtl/ucode_ctrl.sv
verification/ucode_ctrl_asserts.sv
verification/ucode_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the microcode control unit testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ucode_ctrl_tb
FILELIST := ucode_ctrl.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log

# sources are the plain path lines of the file list
SRCS     := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# the verdict is the pass line in the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
